/* flist.f */
rtl/i2c_timing_pkg.sv
rtl/eeprom_txn_pkg.sv
rtl/scl_phase_gen.sv
rtl/eeprom_sequencer.sv
rtl/i2c_bit_engine.sv
rtl/i2c_eeprom_master.sv
tb/eeprom_model.sv
tb/tb_i2c_eeprom_master.sv

/* rtl/eeprom_sequencer.sv */
/*
 * EEPROM frame sequencer, steps through the write or random-read frame
 * and issues one bus slot per step to the bit engine
 */
`timescale 1ns/1ps

module eeprom_sequencer (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    start_write,
    input  logic                                    start_read,
    input  logic [eeprom_txn_pkg::slave_addr_w-1:0] slave_addr,
    input  logic [eeprom_txn_pkg::mem_addr_w-1:0]   mem_addr,
    input  logic [7:0]                              data_in,
    output logic                                    busy,
    output logic                                    done,
    output logic                                    error,
    output logic [7:0]                              data_out,
    output logic                                    slot_go,
    output i2c_timing_pkg::slot_kind_t              slot_kind,
    output logic [7:0]                              tx_byte,
    input  logic                                    slot_busy,
    input  logic                                    slot_done,
    input  logic                                    ack_nack,
    input  logic [7:0]                              rx_byte
);
    import eeprom_txn_pkg::*;
    import i2c_timing_pkg::*;

    seq_step_t               step;
    logic                    is_read;
    logic                    accept;
    logic                    go_pend;
    logic [slave_addr_w-1:0] slave_addr_q;
    logic [mem_addr_w-1:0]   mem_addr_q;
    logic [7:0]              data_q;

    assign accept = (step == s_idle) && (start_write || start_read);

    // Request capture
    always_ff @(posedge clk) begin
        if (accept) begin
            slave_addr_q <= slave_addr;
            mem_addr_q   <= mem_addr;
            data_q       <= data_in;
        end
    end

    // Slot kind and outgoing byte follow the current step
    always_comb begin
        case (step)
            s_start:   slot_kind = slot_start;
            s_restart: slot_kind = slot_restart;
            s_read:    slot_kind = slot_rx_nack;
            s_stop:    slot_kind = slot_stop;
            default:   slot_kind = slot_tx;
        endcase
    end

    always_comb begin
        case (step)
            s_addr_w: tx_byte = {slave_addr_q, 1'b0};
            s_mem_h:  tx_byte = mem_addr_q[mem_addr_w-1 -: 8];
            s_mem_l:  tx_byte = mem_addr_q[7:0];
            s_data:   tx_byte = data_q;
            s_addr_r: tx_byte = {slave_addr_q, 1'b1};
            default:  tx_byte = 8'hff;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step     <= s_idle;
            is_read  <= 1'b0;
            busy     <= 1'b0;
            done     <= 1'b0;
            error    <= 1'b0;
            data_out <= '0;
            slot_go  <= 1'b0;
            go_pend  <= 1'b0;
        end else begin
            done    <= 1'b0;
            slot_go <= 1'b0;
            if (go_pend && !slot_busy) begin
                slot_go <= 1'b1;            // Engine idle, hand over the slot
                go_pend <= 1'b0;
            end
            if (accept) begin
                is_read <= !start_write;    // Write wins on a tie
                error   <= 1'b0;
                busy    <= 1'b1;
                step    <= s_start;
                go_pend <= 1'b1;
            end else if (slot_done) begin
                go_pend <= 1'b1;
                if (ack_nack && slot_kind == slot_tx) begin
                    error <= 1'b1;
                end
                case (step)
                    s_start:   step <= s_addr_w;
                    s_addr_w:  step <= ack_nack ? s_stop : s_mem_h;
                    s_mem_h:   step <= ack_nack ? s_stop : s_mem_l;
                    s_mem_l: begin
                        if (ack_nack) begin
                            step <= s_stop;
                        end else begin
                            step <= is_read ? s_restart : s_data;
                        end
                    end
                    s_data:    step <= s_stop;  // STOP follows even after a NACK
                    s_restart: step <= s_addr_r;
                    s_addr_r:  step <= ack_nack ? s_stop : s_read;
                    s_read: begin
                        data_out <= rx_byte;
                        step     <= s_stop;
                    end
                    default: begin
                        // STOP done, frame complete
                        go_pend <= 1'b0;
                        busy    <= 1'b0;
                        done    <= 1'b1;
                        step    <= s_idle;
                    end
                endcase
            end
        end
    end

    a_done_after_busy : assert property (
        @(posedge clk) disable iff (!rst_n)
        done |-> $past(busy)
    );

endmodule

/* rtl/eeprom_txn_pkg.sv */
/*
 * EEPROM transaction definitions: address widths and the steps of the
 * single-byte write and random-read frames
 */
package eeprom_txn_pkg;

    // 16-bit word address of the 32-kbit part
    localparam int mem_addr_w = 16;

    // 7-bit I2C slave address, direction bit appended on the bus
    localparam int slave_addr_w = 7;

    /*
     * Write frame: start, addr_w, mem_h, mem_l, data, stop
     * Read frame:  start, addr_w, mem_h, mem_l, restart, addr_r, read, stop
     */
    typedef enum logic [3:0] {
        s_idle,
        s_start,
        s_addr_w,       // Slave address with write bit
        s_mem_h,        // Word address high byte
        s_mem_l,        // Word address low byte
        s_data,         // Write data byte
        s_restart,
        s_addr_r,       // Slave address with read bit
        s_read,         // Data byte in, NACK out
        s_stop
    } seq_step_t;

endpackage

/* rtl/i2c_bit_engine.sv */
/*
 * I2C bit engine, runs one slot on SCL and SDA in quarter phases:
 * drive at 0, SCL high at 1, sample at 2, SCL low at 3
 */
`timescale 1ns/1ps

module i2c_bit_engine (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       phase_tick,
    input  i2c_timing_pkg::phase_t     phase,
    input  logic                       slot_go,
    input  i2c_timing_pkg::slot_kind_t slot_kind,
    input  logic [7:0]                 tx_byte,
    output logic                       slot_busy,
    output logic                       slot_done,
    output logic                       ack_nack,
    output logic [7:0]                 rx_byte,
    output logic                       scl,
    output logic                       sda_out,
    output logic                       sda_oe,
    input  logic                       sda_in
);
    import i2c_timing_pkg::*;

    localparam int cnt_w = $clog2(byte_bits + 1);

    slot_kind_t       kind_q;
    logic [7:0]       shift_q;
    logic [cnt_w-1:0] bit_cnt;
    logic             is_byte;
    logic             last_bit;
    logic             slot_end;

    assign is_byte  = (kind_q == slot_tx) || (kind_q == slot_rx_nack);
    assign last_bit = !is_byte || (bit_cnt == cnt_w'(byte_bits));  // ACK/NACK bit is last
    assign slot_end = slot_busy && phase_tick && (phase == 2'd3) && last_bit;

    // Shift register, loaded with the tx byte, fills with rx bits
    always_ff @(posedge clk) begin
        if (slot_go) begin
            shift_q <= tx_byte;
        end else if (slot_busy && phase_tick && !last_bit) begin
            if (phase == 2'd2 && kind_q == slot_rx_nack) begin
                shift_q <= {shift_q[6:0], sda_in};
            end else if (phase == 2'd3 && kind_q == slot_tx) begin
                shift_q <= {shift_q[6:0], 1'b0};
            end
        end
        if (slot_end && kind_q == slot_rx_nack) begin
            rx_byte <= shift_q;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            kind_q    <= slot_stop;
            bit_cnt   <= '0;
            slot_busy <= 1'b0;
            slot_done <= 1'b0;
            ack_nack  <= 1'b0;
            scl       <= 1'b1;
            sda_out   <= 1'b1;
            sda_oe    <= 1'b0;
        end else begin
            slot_done <= 1'b0;
            if (slot_go) begin
                kind_q    <= slot_kind;
                bit_cnt   <= '0;
                ack_nack  <= 1'b0;
                slot_busy <= 1'b1;
            end else if (slot_busy && phase_tick) begin
                case (phase)
                    2'd0: begin
                        case (kind_q)
                            slot_start: begin
                                scl     <= 1'b1;
                                sda_oe  <= 1'b1;
                                sda_out <= 1'b1;
                            end
                            slot_restart: begin
                                sda_oe  <= 1'b1;
                                sda_out <= 1'b1;
                            end
                            slot_stop: begin
                                sda_oe  <= 1'b1;
                                sda_out <= 1'b0;
                            end
                            slot_tx: begin
                                sda_oe  <= !last_bit;            // Release for slave ACK
                                sda_out <= last_bit | shift_q[7];
                            end
                            default: begin
                                sda_oe  <= last_bit;             // NACK after the data bits
                                sda_out <= 1'b1;
                            end
                        endcase
                    end
                    2'd1: begin
                        if (kind_q == slot_start) begin
                            sda_out <= 1'b0;                     // START, SDA falls with SCL high
                        end else begin
                            scl <= 1'b1;
                        end
                    end
                    2'd2: begin
                        if (kind_q == slot_start) begin
                            scl <= 1'b0;
                        end else if (kind_q == slot_restart) begin
                            sda_out <= 1'b0;                     // Repeated START
                        end else if (kind_q == slot_stop) begin
                            sda_out <= 1'b1;                     // STOP, SDA rises with SCL high
                        end else if (kind_q == slot_tx && last_bit) begin
                            ack_nack <= sda_in;
                        end
                    end
                    default: begin
                        if (kind_q == slot_stop) begin
                            sda_oe <= 1'b0;                      // Bus back to idle
                        end else begin
                            scl <= 1'b0;
                        end
                        if (last_bit) begin
                            slot_busy <= 1'b0;
                            slot_done <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                endcase
            end
        end
    end

    // Data bits and ACK only change while SCL is low
    a_sda_stable : assert property (
        @(posedge clk) disable iff (!rst_n)
        (slot_busy && is_byte && scl && $past(scl)) |-> $stable(sda_out)
    );

    a_go_when_idle : assert property (
        @(posedge clk) disable iff (!rst_n)
        slot_go |-> !slot_busy
    );

endmodule

/* rtl/i2c_eeprom_master.sv */
/*
 * I2C master for a 32-kbit EEPROM, single-byte write and random read
 */
`timescale 1ns/1ps

module i2c_eeprom_master (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    start_write,
    input  logic                                    start_read,
    input  logic [eeprom_txn_pkg::slave_addr_w-1:0] slave_addr,
    input  logic [eeprom_txn_pkg::mem_addr_w-1:0]   mem_addr,
    input  logic [7:0]                              data_in,
    output logic                                    busy,
    output logic                                    done,
    output logic                                    error,
    output logic [7:0]                              data_out,
    output logic                                    scl,
    output logic                                    sda_out,
    output logic                                    sda_oe,
    input  logic                                    sda_in
);
    import i2c_timing_pkg::*;

    logic       phase_tick;
    phase_t     phase;
    logic       slot_go;
    slot_kind_t slot_kind;
    logic [7:0] tx_byte;
    logic       slot_busy;
    logic       slot_done;
    logic       ack_nack;
    logic [7:0] rx_byte;

    scl_phase_gen scl_phase_gen_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .active     (busy),             // Runs only during a transaction
        .phase_tick (phase_tick),
        .phase      (phase)
    );

    eeprom_sequencer eeprom_sequencer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_write (start_write),
        .start_read  (start_read),
        .slave_addr  (slave_addr),
        .mem_addr    (mem_addr),
        .data_in     (data_in),
        .busy        (busy),
        .done        (done),
        .error       (error),
        .data_out    (data_out),
        .slot_go     (slot_go),
        .slot_kind   (slot_kind),
        .tx_byte     (tx_byte),
        .slot_busy   (slot_busy),
        .slot_done   (slot_done),
        .ack_nack    (ack_nack),
        .rx_byte     (rx_byte)
    );

    i2c_bit_engine i2c_bit_engine_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .phase_tick (phase_tick),
        .phase      (phase),
        .slot_go    (slot_go),
        .slot_kind  (slot_kind),
        .tx_byte    (tx_byte),
        .slot_busy  (slot_busy),
        .slot_done  (slot_done),
        .ack_nack   (ack_nack),
        .rx_byte    (rx_byte),
        .scl        (scl),
        .sda_out    (sda_out),
        .sda_oe     (sda_oe),
        .sda_in     (sda_in)
    );

endmodule

/* rtl/i2c_timing_pkg.sv */
/*
 * I2C bus timing definitions shared by the phase generator, the
 * sequencer and the bit engine
 */
package i2c_timing_pkg;

    // clk cycles per SCL quarter phase, about 378 kHz SCL from 100 MHz
    localparam int clk_div = 66;

    // Data bits carried by one byte slot, the ACK bit comes on top
    localparam int byte_bits = 8;

    // Quarter-phase index inside one SCL bit
    typedef logic [1:0] phase_t;

    // One slot is a single bus action issued by the sequencer
    typedef enum logic [2:0] {
        slot_start,     // START from idle bus
        slot_restart,   // Repeated START
        slot_tx,        // 8 bits out, ACK sampled
        slot_rx_nack,   // 8 bits in, NACK driven
        slot_stop       // STOP, bus released
    } slot_kind_t;

endpackage

/* rtl/scl_phase_gen.sv */
/*
 * SCL phase generator, one tick per quarter phase while a
 * transaction is active
 */
`timescale 1ns/1ps

module scl_phase_gen (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   active,
    output logic                   phase_tick,
    output i2c_timing_pkg::phase_t phase
);
    import i2c_timing_pkg::*;

    localparam int cnt_w = $clog2(clk_div);

    logic [cnt_w-1:0] div_cnt;
    logic             div_wrap;

    assign div_wrap = (div_cnt == cnt_w'(clk_div - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt    <= '0;
            phase_tick <= 1'b0;
            phase      <= '0;
        end else if (!active) begin
            div_cnt    <= '0;               // Next transaction starts at phase 0
            phase_tick <= 1'b0;
            phase      <= '0;
        end else begin
            phase_tick <= div_wrap;
            div_cnt    <= div_wrap ? '0 : div_cnt + 1'b1;
            if (phase_tick) begin
                phase <= phase + 2'd1;      // Advance after the tick is seen
            end
        end
    end

    a_tick_single : assert property (
        @(posedge clk) disable iff (!rst_n)
        phase_tick |=> !phase_tick
    );

endmodule

/* run.sh */
#!/bin/sh
# Build and run the I2C EEPROM master testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module tb_i2c_eeprom_master -o sim > build.log 2>&1 \
    && ./obj_dir/sim > sim.log 2>&1 \
    || { echo "Build or simulation run failed"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q '\*\*\* PASSED \*\*\*' sim.log || { echo "No verdict in log"; exit 1; }
exit 0

/* tb/eeprom_model.sv */
/*
 * Behavioral I2C EEPROM slave, open drain, 16-bit word address,
 * single-byte write and random read from a 4096-byte memory
 */
`timescale 1ns/1ps

module eeprom_model (
    input  logic scl,
    input  logic sda,
    output logic sda_low
);
    localparam int         mem_depth = 4096;
    localparam logic [6:0] dev_addr  = 7'h50;

    localparam int m_idle  = 0;
    localparam int m_addr  = 1;
    localparam int m_mem_h = 2;
    localparam int m_mem_l = 3;
    localparam int m_data  = 4;
    localparam int m_read  = 5;

    logic [7:0]  mem [0:mem_depth-1];
    logic [7:0]  shreg;
    logic [7:0]  rd_byte;
    logic [15:0] ptr;
    int          mode;
    int          bit_cnt;
    logic        in_ack;
    logic        scl_q;
    logic        sda_q;

    initial begin
        for (int i = 0; i < mem_depth; i++) begin
            mem[i] = 8'(i) ^ {4'h0, 4'(i >> 8)} ^ 8'h5a;   // Every address bit shows up
        end
        sda_low = 1'b0;
        mode    = m_idle;
        bit_cnt = 0;
        in_ack  = 1'b0;
        ptr     = '0;
        shreg   = '0;
        rd_byte = '0;
        scl_q   = 1'b1;
        sda_q   = 1'b1;
    end

    // Acts on a complete byte from the master and sets up the ACK bit
    task accept_byte;
        sda_low = 1'b1;
        case (mode)
            m_addr: begin
                if (shreg[7:1] != dev_addr) begin
                    sda_low = 1'b0;
                    mode    = m_idle;
                end else if (shreg[0]) begin
                    rd_byte = mem[ptr[11:0]];
                    mode    = m_read;
                end else begin
                    mode = m_mem_h;
                end
            end
            m_mem_h: begin
                if (shreg >= 8'h10) begin
                    sda_low = 1'b0;                 // Outside the 4 KB range
                    mode    = m_idle;
                end else begin
                    ptr[15:8] = shreg;
                    mode      = m_mem_l;
                end
            end
            m_mem_l: begin
                ptr[7:0] = shreg;
                mode     = m_data;
            end
            default: begin
                mem[ptr[11:0]] = shreg;
                mode           = m_idle;
            end
        endcase
    endtask

    always @(scl or sda) begin
        if (scl_q && scl && sda_q && !sda) begin
            mode    = m_addr;                       // START or repeated START
            bit_cnt = 0;
            in_ack  = 1'b0;
            sda_low = 1'b0;
        end else if (scl_q && scl && !sda_q && sda) begin
            mode    = m_idle;                       // STOP
            in_ack  = 1'b0;
            sda_low = 1'b0;
        end else if (!scl_q && scl) begin
            if (!in_ack && mode >= m_addr && mode <= m_data) begin
                shreg   = {shreg[6:0], sda};
                bit_cnt = bit_cnt + 1;
            end else if (!in_ack && mode == m_read) begin
                bit_cnt = bit_cnt + 1;
            end
        end else if (scl_q && !scl) begin
            if (in_ack) begin
                in_ack  = 1'b0;
                sda_low = 1'b0;
                if (mode == m_read) begin
                    bit_cnt = 0;
                    sda_low = !rd_byte[7];
                end
            end else if (mode >= m_addr && mode <= m_data && bit_cnt == 8) begin
                bit_cnt = 0;
                in_ack  = 1'b1;
                accept_byte();
            end else if (mode == m_read) begin
                if (bit_cnt < 8) begin
                    sda_low = !rd_byte[7 - bit_cnt];
                end else begin
                    sda_low = 1'b0;                 // Master answers with NACK
                    in_ack  = 1'b1;
                    mode    = m_idle;
                end
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

/* tb/tb_i2c_eeprom_master.sv */
/*
 * Testbench for the I2C EEPROM master, directed write and read tests
 * against a behavioral EEPROM on an open-drain bus
 */
`timescale 1ns/1ps

module tb_i2c_eeprom_master;
    localparam int          timeout_cycles = 250000;
    localparam logic [6:0]  eeprom_addr    = 7'h50;
    localparam logic [31:0] lfsr_seed      = 32'hd43b4a5a;

    logic        clk;
    logic        rst_n;
    logic        start_write;
    logic        start_read;
    logic [6:0]  slave_addr;
    logic [15:0] mem_addr;
    logic [7:0]  data_in;
    logic        busy;
    logic        done;
    logic        error;
    logic [7:0]  data_out;
    logic        scl;
    logic        sda_out;
    logic        sda_oe;
    logic        model_sda_low;
    wire         sda;

    int          errors;
    int          checks;
    int          cycles = 0;
    logic [31:0] lfsr;
    logic [7:0]  sb [int];
    logic [15:0] known_addr;
    logic        got_error;
    logic [7:0]  got_data;

    assign sda = !((sda_oe && !sda_out) || model_sda_low);  // Pull-up unless pulled low

    i2c_eeprom_master i2c_eeprom_master_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_write (start_write),
        .start_read  (start_read),
        .slave_addr  (slave_addr),
        .mem_addr    (mem_addr),
        .data_in     (data_in),
        .busy        (busy),
        .done        (done),
        .error       (error),
        .data_out    (data_out),
        .scl         (scl),
        .sda_out     (sda_out),
        .sda_oe      (sda_oe),
        .sda_in      (sda)
    );

    eeprom_model eeprom_model_i (
        .scl     (scl),
        .sda     (sda),
        .sda_low (model_sda_low)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("ERROR: timeout after %0d cycles, the DUT never finished", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL %s: expected %0h, actual %0h", name, exp, got);
        end
    endtask

    task automatic run_txn(input logic is_read, input logic [6:0] sa,
                           input logic [15:0] addr, input logic [7:0] d);
        @(negedge clk);
        slave_addr  = sa;
        mem_addr    = addr;
        data_in     = d;
        start_write = !is_read;
        start_read  = is_read;
        @(negedge clk);
        start_write = 1'b0;
        start_read  = 1'b0;
        check_val("busy after request", 1, busy);
        while (!done) @(negedge clk);
        got_error = error;
        got_data  = data_out;
        check_val("busy at done", 0, busy);
    endtask

    task automatic write_byte(input string name, input logic [15:0] addr,
                              input logic [7:0] d, input logic exp_err);
        run_txn(1'b0, eeprom_addr, addr, d);
        check_val({name, " write error"}, exp_err, got_error);
        if (!exp_err) begin
            sb[addr] = d;
        end
    endtask

    task automatic read_byte(input string name, input logic [6:0] sa,
                             input logic [15:0] addr, input logic exp_err);
        run_txn(1'b1, sa, addr, 8'h00);
        check_val({name, " read error"}, exp_err, got_error);
        if (!exp_err) begin
            check_val({name, " read data"}, sb[addr], got_data);
        end
    endtask

    task automatic expect_reset_state;
        check_val("reset busy", 0, busy);
        check_val("reset done", 0, done);
        check_val("reset error", 0, error);
        check_val("reset data_out", 0, data_out);
        check_val("reset scl", 1, scl);
        check_val("reset sda_oe", 0, sda_oe);
        check_val("reset sda_out", 1, sda_out);
        check_val("reset sda", 1, sda);
    endtask

    task automatic write_read_random;
        logic [31:0] a;
        logic [31:0] d;
        for (int i = 0; i < 4; i++) begin
            rand_bits(12, a);                       // Below 4096
            rand_bits(8, d);
            write_byte("random pair", a[15:0], d[7:0], 1'b0);
            read_byte("random pair", eeprom_addr, a[15:0], 1'b0);
            if (i == 0) begin
                known_addr = a[15:0];
            end
        end
    endtask

    // Addresses differ only in the high byte
    task automatic full_address_decode;
        write_byte("full address lo", 16'h0000, 8'h3c, 1'b0);
        write_byte("full address hi", 16'h0f00, 8'hc3, 1'b0);
        read_byte("full address hi", eeprom_addr, 16'h0f00, 1'b0);
        read_byte("full address lo", eeprom_addr, 16'h0000, 1'b0);
    endtask

    task automatic bad_slave_recovery;
        read_byte("bad slave", 7'h51, known_addr, 1'b1);
        read_byte("after bad slave", eeprom_addr, known_addr, 1'b0);
    endtask

    // 16'h2000 would alias to 16'h0000 inside a 4 KB array
    task automatic out_of_range_write;
        write_byte("out of range", 16'h2000, 8'h77, 1'b1);
        read_byte("after out of range", eeprom_addr, 16'h0000, 1'b0);
    endtask

    task automatic ignore_while_busy;
        int dones;
        @(negedge clk);
        slave_addr  = eeprom_addr;
        mem_addr    = known_addr;
        data_in     = 8'h96;
        start_write = 1'b1;
        @(negedge clk);
        start_write = 1'b0;
        repeat (20) @(negedge clk);
        data_in     = 8'h69;                        // Must never reach the memory
        start_write = 1'b1;
        @(negedge clk);
        start_write = 1'b0;
        while (!done) @(negedge clk);
        dones = 1;
        check_val("busy ignore write error", 0, error);
        sb[known_addr] = 8'h96;
        repeat (300) begin
            @(negedge clk);
            if (done || busy) begin
                dones++;
            end
        end
        check_val("busy ignore done count", 1, dones);
        read_byte("busy ignore", eeprom_addr, known_addr, 1'b0);
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        start_write = 1'b0;
        start_read  = 1'b0;
        slave_addr  = '0;
        mem_addr    = '0;
        data_in     = '0;
        errors      = 0;
        checks      = 0;
        lfsr        = lfsr_seed;
        known_addr  = '0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        expect_reset_state();
        write_read_random();
        full_address_decode();
        bad_slave_recovery();
        out_of_range_write();
        ignore_while_busy();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
